// ==== list.f ====
source/max7219_pkg.sv
source/uart_rx.sv
source/cmd_assembler.sv
source/max7219_serializer.sv
source/max7219_uart_ctrl.sv
testbench/max7219_uart_ctrl_asserts.sv
testbench/tb_max7219_uart_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MAX7219 UART controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_max7219_uart_ctrl -o sim

out=$(./obj_dir/sim +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

// ==== testbench/tb_max7219_uart_ctrl.sv ====
// ============================================================
// Testbench for the MAX7219 UART display controller
// Sends address and data bytes over UART, captures the
// serial frames and compares them with the expected ones
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module tb_max7219_uart_ctrl;
   import max7219_pkg::*;

   localparam int CLKS_PER_BIT  = 16;
   localparam int HALF_PERIOD   = 2;
   localparam int LOAD_DURATION = 4;
   localparam int CLK_PERIOD    = 20;

   // Config 8, digits 16, bad address 3, bad stop 6
   localparam int NUM_BYTES   = 33;
   localparam int WATCHDOG_NS = NUM_BYTES * 10 * CLKS_PER_BIT * CLK_PERIOD * 3 / 2;

   logic clk     = 1'b0;
   logic i_reset = 1'b1;
   logic i_rx    = 1'b1;
   logic o_max7219_clk;
   logic o_max7219_data;
   logic o_max7219_load;

   // Expected frames with the name of the test that sent them
   max_frame_t exp_q[$];
   string      name_q[$];

   max_frame_t  cap_bits = '0;
   int          cap_cnt  = 0;
   logic [31:0] lfsr_state = 32'h5952f694;

   always #(CLK_PERIOD / 2) clk = ~clk;

   max7219_uart_ctrl #(
      .CLKS_PER_BIT  (CLKS_PER_BIT),
      .HALF_PERIOD   (HALF_PERIOD),
      .LOAD_DURATION (LOAD_DURATION)
   ) i_dut (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_rx           (i_rx),
      .o_max7219_clk  (o_max7219_clk),
      .o_max7219_data (o_max7219_data),
      .o_max7219_load (o_max7219_load)
   );

   bind max7219_uart_ctrl max7219_uart_ctrl_asserts #(
      .LOAD_DURATION (LOAD_DURATION)
   ) u_asserts (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_max7219_clk  (o_max7219_clk),
      .i_max7219_data (o_max7219_data),
      .i_max7219_load (o_max7219_load)
   );

   // ============================================================
   // Helpers
   // ============================================================
   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_byte(output uart_byte_t b);
      for (int i = 0; i < 8; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         b[i]       = lfsr_state[0];
      end
   endtask

   // Four zero bits, address nibble, data byte
   task automatic expect_frame(input uart_byte_t addr, input uart_byte_t data,
                               input string name);
      exp_q.push_back({4'h0, addr[3:0], data});
      name_q.push_back(name);
   endtask

   // One UART bit held from a falling edge
   task automatic hold_bit(input logic v);
      i_rx = v;
      repeat (CLKS_PER_BIT) @(negedge clk);
   endtask

   // Start, 8 bits LSB first, stop, then one idle bit
   task automatic send_uart_byte(input uart_byte_t b, input logic bad_stop);
      hold_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         hold_bit(b[i]);
      end
      hold_bit(!bad_stop);
      hold_bit(1'b1);
   endtask

   task automatic send_command(input uart_byte_t addr, input uart_byte_t data,
                               input string name);
      expect_frame(addr, data, name);
      send_uart_byte(addr, 1'b0);
      send_uart_byte(data, 1'b0);
   endtask

   task automatic compare_frame();
      max_frame_t exp;
      string      name;
      assert (exp_q.size() != 0)
         else stop_with_failure("Load pulse on the MAX7219 outputs with no frame expected");
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      assert (cap_cnt == FRAME_BITS)
         else stop_with_failure($sformatf("Error %s: expected %0d clock edges, actual %0d",
                                          name, FRAME_BITS, cap_cnt));
      assert (cap_bits == exp)
         else stop_with_failure($sformatf("Error %s: expected %h, actual %h",
                                          name, exp, cap_bits));
      cap_cnt = 0;
   endtask

   // ============================================================
   // Frame capture on each rising chip clock
   // ============================================================
   always @(posedge o_max7219_clk or posedge o_max7219_load) begin
      if (o_max7219_load) begin
         compare_frame();
      end else begin
         cap_bits = {cap_bits[FRAME_BITS-2:0], o_max7219_data};
         cap_cnt  = cap_cnt + 1;
      end
   end

   // Bound protocol checks
   always @(negedge clk) begin
      assert (!i_dut.u_asserts.any_fail)
         else stop_with_failure("A protocol check on the MAX7219 outputs failed");
   end

   initial begin
      #(WATCHDOG_NS);
      stop_with_failure("Timeout, the frames did not all come out in time");
   end

   // ============================================================
   // Stimulus
   // ============================================================
   initial begin
      uart_byte_t data;
      repeat (3) @(negedge clk);
      i_reset = 1'b0;

      // Quiet outputs with the line idle
      repeat (20) begin
         @(negedge clk);
         assert (!o_max7219_clk && !o_max7219_data && !o_max7219_load)
            else stop_with_failure("MAX7219 outputs active with no input after reset");
      end

      // Config registers 0x9 to 0xC
      for (int a = 9; a <= 12; a++) begin
         random_byte(data);
         send_command(uart_byte_t'(a), data, "config");
      end

      // Digits 0x1 to 0x8 back to back
      for (int a = 1; a <= 8; a++) begin
         random_byte(data);
         send_command(uart_byte_t'(a), data, "digits");
      end

      // Out of range address is skipped
      send_uart_byte(8'h3A, 1'b0);
      random_byte(data);
      send_command(8'h05, data, "bad_address");

      // Low stop bit on a data byte so the next byte pairs instead
      random_byte(data);
      expect_frame(8'h02, data, "bad_stop");
      send_uart_byte(8'h02, 1'b0);
      send_uart_byte(8'h6E, 1'b1);
      send_uart_byte(data, 1'b0);
      // Low stop bit in the address position
      send_uart_byte(8'h07, 1'b1);
      random_byte(data);
      send_command(8'h06, data, "bad_stop");

      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      // Quiet time where a stray frame would show up
      repeat (2 * 10 * CLKS_PER_BIT) @(negedge clk);

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/max7219_uart_ctrl_asserts.sv ====
// ============================================================
// MAX7219 output protocol checks
// Bound to the controller top level, watches the chip clock,
// data and load lines against the frame rules
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module max7219_uart_ctrl_asserts #(
   parameter int LOAD_DURATION = 4
) (
   input logic clk,
   input logic i_reset,
   input logic i_max7219_clk,
   input logic i_max7219_data,
   input logic i_max7219_load
);
   import max7219_pkg::*;

   // Failure counts, one per check
   int unsigned data_fails  = 0;
   int unsigned load_fails  = 0;
   int unsigned edge_fails  = 0;
   int unsigned len_fails   = 0;
   logic        any_fail;

   logic        mclk_q;
   int unsigned rise_cnt;
   int unsigned load_len;

   assign any_fail = (data_fails + load_fails + edge_fails + len_fails) != 0;

   // Rising chip clock edges since the last load, and load width
   always_ff @(posedge clk) begin
      if (i_reset) begin
         mclk_q   <= 1'b0;
         rise_cnt <= 0;
         load_len <= 0;
      end else begin
         mclk_q <= i_max7219_clk;
         if (i_max7219_load) begin
            rise_cnt <= 0;
         end else if (i_max7219_clk && !mclk_q) begin
            rise_cnt <= rise_cnt + 1;
         end
         load_len <= i_max7219_load ? load_len + 1 : 0;
      end
   end

   // ============================================================
   // Protocol checks
   // ============================================================
   data_stable_a: assert property (@(posedge clk) disable iff (i_reset)
      i_max7219_clk |-> $stable(i_max7219_data))
      else begin
         data_fails++;
         $error("MAX7219 data changed while its clock was high");
      end

   load_clk_a: assert property (@(posedge clk) disable iff (i_reset)
      !(i_max7219_load && i_max7219_clk))
      else begin
         load_fails++;
         $error("MAX7219 load high while its clock was high");
      end

   // Full frame of clock edges before each latch
   edge_count_a: assert property (@(posedge clk) disable iff (i_reset)
      $rose(i_max7219_load) |-> (rise_cnt == FRAME_BITS))
      else begin
         edge_fails++;
         $error("Wrong number of MAX7219 clock edges before load");
      end

   load_len_a: assert property (@(posedge clk) disable iff (i_reset)
      $fell(i_max7219_load) |-> (load_len == LOAD_DURATION))
      else begin
         len_fails++;
         $error("MAX7219 load pulse had the wrong length");
      end

endmodule

`default_nettype wire

// ==== source/max7219_uart_ctrl.sv ====
// ============================================================
// MAX7219 UART display controller, top level
// UART receiver, command assembler and serializer in a row
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module max7219_uart_ctrl #(
   parameter int CLKS_PER_BIT  = 16,
   parameter int HALF_PERIOD   = 2,
   parameter int LOAD_DURATION = 4
) (
   input  logic clk,
   input  logic i_reset,
   input  logic i_rx,
   output logic o_max7219_clk,
   output logic o_max7219_data,
   output logic o_max7219_load
);
   import max7219_pkg::*;

   // Receiver to assembler
   uart_byte_t rx_byte;
   logic       rx_byte_valid;

   // Assembler to serializer
   max_frame_t frame;
   logic       frame_valid;
   logic       frame_ready;

   // ============================================================
   // Input side
   // ============================================================
   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_rx (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_rx         (i_rx),
      .o_byte       (rx_byte),
      .o_byte_valid (rx_byte_valid)
   );

   // Address and data pairing
   cmd_assembler u_cmd_assembler (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_byte        (rx_byte),
      .i_byte_valid  (rx_byte_valid),
      .o_frame       (frame),
      .o_frame_valid (frame_valid),
      .i_frame_ready (frame_ready)
   );

   // ============================================================
   // Output side
   // ============================================================
   max7219_serializer #(
      .HALF_PERIOD   (HALF_PERIOD),
      .LOAD_DURATION (LOAD_DURATION)
   ) u_max7219_serializer (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_frame        (frame),
      .i_frame_valid  (frame_valid),
      .o_frame_ready  (frame_ready),
      .o_max7219_clk  (o_max7219_clk),
      .o_max7219_data (o_max7219_data),
      .o_max7219_load (o_max7219_load)
   );

endmodule

`default_nettype wire

// ==== source/max7219_serializer.sv ====
// ============================================================
// MAX7219 serializer
// Shifts a 16-bit frame MSB first on the chip clock and data
// lines, then pulses load to latch it
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module max7219_serializer #(
   parameter int HALF_PERIOD   = 2,
   parameter int LOAD_DURATION = 4
) (
   input  logic                    clk,
   input  logic                    i_reset,
   input  max7219_pkg::max_frame_t i_frame,
   input  logic                    i_frame_valid,
   output logic                    o_frame_ready,
   output logic                    o_max7219_clk,
   output logic                    o_max7219_data,
   output logic                    o_max7219_load
);
   import max7219_pkg::*;

   // Counter widths and terminal counts
   localparam int HCNT_W = $clog2(HALF_PERIOD + 1);
   localparam int LCNT_W = $clog2(LOAD_DURATION + 1);
   localparam int BCNT_W = $clog2(FRAME_BITS);
   localparam logic [HCNT_W-1:0] HALF_LAST = HCNT_W'(HALF_PERIOD - 1);
   localparam logic [LCNT_W-1:0] LOAD_LAST = LCNT_W'(LOAD_DURATION - 1);
   localparam logic [BCNT_W-1:0] BIT_LAST  = BCNT_W'(FRAME_BITS - 1);

   ser_state_t        state;
   logic [HCNT_W-1:0] half_cnt;
   logic [LCNT_W-1:0] load_cnt;
   logic [BCNT_W-1:0] bit_cnt;
   max_frame_t        shreg;
   logic              take;
   logic              clk_fall;

   // Frame accepted from the assembler
   assign take = (state == SER_IDLE) && i_frame_valid && o_frame_ready;

   // End of a high half period, the chip clock falls here
   assign clk_fall = (state == SER_SHIFT) && (half_cnt == HALF_LAST) && o_max7219_clk;

   // ============================================================
   // Serializer FSM
   // ============================================================
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state          <= SER_IDLE;
         half_cnt       <= '0;
         load_cnt       <= '0;
         bit_cnt        <= '0;
         o_frame_ready  <= 1'b1;
         o_max7219_clk  <= 1'b0;
         o_max7219_data <= 1'b0;
         o_max7219_load <= 1'b0;
      end else begin
         case (state)
            SER_IDLE: begin
               half_cnt <= '0;
               load_cnt <= '0;
               bit_cnt  <= '0;
               if (take) begin
                  // MSB out first, clock still low
                  o_frame_ready  <= 1'b0;
                  o_max7219_data <= i_frame[FRAME_BITS-1];
                  state          <= SER_SHIFT;
               end else begin
                  // Ready one cycle after load went low
                  o_frame_ready <= 1'b1;
               end
            end
            SER_SHIFT: begin
               if (half_cnt == HALF_LAST) begin
                  half_cnt <= '0;
                  if (!o_max7219_clk) begin
                     // Rising edge, chip samples data
                     o_max7219_clk <= 1'b1;
                  end else begin
                     o_max7219_clk <= 1'b0;
                     if (bit_cnt == BIT_LAST) begin
                        // Last bit done, latch the frame
                        o_max7219_data <= 1'b0;
                        o_max7219_load <= 1'b1;
                        state          <= SER_LOAD;
                     end else begin
                        // Next bit during the low phase
                        o_max7219_data <= shreg[FRAME_BITS-1];
                        bit_cnt        <= bit_cnt + 1'b1;
                     end
                  end
               end else begin
                  half_cnt <= half_cnt + 1'b1;
               end
            end
            SER_LOAD: begin
               if (load_cnt == LOAD_LAST) begin
                  o_max7219_load <= 1'b0;
                  state          <= SER_IDLE;
               end else begin
                  load_cnt <= load_cnt + 1'b1;
               end
            end
            default: state <= SER_IDLE;
         endcase
      end
   end

   // Remaining bits, MSB already on the data line
   always_ff @(posedge clk) begin
      if (take) begin
         shreg <= {i_frame[FRAME_BITS-2:0], 1'b0};
      end else if (clk_fall) begin
         shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

// ==== source/cmd_assembler.sv ====
// ============================================================
// Command assembler
// Pairs an address byte with the next data byte and holds
// the resulting MAX7219 frame until the serializer takes it
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module cmd_assembler (
   input  logic                    clk,
   input  logic                    i_reset,
   input  max7219_pkg::uart_byte_t i_byte,
   input  logic                    i_byte_valid,
   output max7219_pkg::max_frame_t o_frame,
   output logic                    o_frame_valid,
   input  logic                    i_frame_ready
);
   import max7219_pkg::*;

   logic       addr_held;
   max_addr_t  addr_reg;
   logic       addr_ok;
   logic       frame_pending;
   logic       take_data;

   // Only registers 0x0 to 0xF exist on the chip
   assign addr_ok = (i_byte[7:4] == 4'h0);

   // Frame still waiting and not leaving on this edge
   assign frame_pending = o_frame_valid && !i_frame_ready;

   // Second byte of a pair that can be accepted
   assign take_data = i_byte_valid && addr_held && !frame_pending;

   // ============================================================
   // Pairing control
   // ============================================================
   always_ff @(posedge clk) begin
      if (i_reset) begin
         addr_held     <= 1'b0;
         o_frame_valid <= 1'b0;
      end else begin
         // Handshake with serializer
         if (o_frame_valid && i_frame_ready) begin
            o_frame_valid <= 1'b0;
         end
         if (i_byte_valid) begin
            if (!addr_held) begin
               // Bad address leaves the flag clear, next byte is an address again
               addr_held <= addr_ok;
            end else begin
               // Data byte closes the pair, dropped if a frame waits
               addr_held <= 1'b0;
               if (take_data) begin
                  o_frame_valid <= 1'b1;
               end
            end
         end
      end
   end

   // Address and frame payload
   always_ff @(posedge clk) begin
      if (i_byte_valid && !addr_held && addr_ok) begin
         addr_reg <= max_addr_t'(i_byte[3:0]);
      end
      if (take_data) begin
         o_frame <= {4'h0, addr_reg, max_data_t'(i_byte)};
      end
   end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
// ============================================================
// UART receiver, 8 data bits, no parity, one stop bit
// Samples each bit at its middle, LSB first, and drops
// false starts and bytes with a low stop bit
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_rx,
   output max7219_pkg::uart_byte_t o_byte,
   output logic                    o_byte_valid
);
   import max7219_pkg::*;

   // Bit timing counter, wide enough for one full bit
   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] MID_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

   rx_state_t        state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic             rx_meta;
   logic             rx_sync;
   uart_byte_t       rx_shift;
   logic             bit_mid;

   // Two flops against metastability, line idles high
   always_ff @(posedge clk) begin
      if (i_reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   // Middle of a data or stop bit
   assign bit_mid = (cnt == BIT_LAST);

   // ============================================================
   // Receiver FSM
   // ============================================================
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state        <= RX_IDLE;
         cnt          <= '0;
         bit_idx      <= '0;
         o_byte_valid <= 1'b0;
      end else begin
         // Strobe lasts one cycle only
         o_byte_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               cnt     <= '0;
               bit_idx <= '0;
               // Falling edge, possible start bit
               if (!rx_sync) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (cnt == MID_LAST) begin
                  cnt <= '0;
                  // Still low at mid bit, else a glitch
                  state <= rx_sync ? RX_IDLE : RX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_mid) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_mid) begin
                  cnt <= '0;
                  // Framing error gives no strobe
                  o_byte_valid <= rx_sync;
                  state        <= RX_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Data shift, LSB arrives first so shift towards bit 0
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_mid) begin
         rx_shift <= {rx_sync, rx_shift[7:1]};
      end
   end

   assign o_byte = rx_shift;

endmodule

`default_nettype wire

// ==== source/max7219_pkg.sv ====
// ============================================================
// MAX7219 UART controller shared definitions
// Widths of bytes, addresses, data and frames, plus the
// state encodings of the receiver and serializer FSMs
// ============================================================
`default_nettype none

package max7219_pkg;

   // ============================================================
   // Widths
   // ============================================================

   // One UART character, 8N1
   typedef logic [7:0] uart_byte_t;

   // MAX7219 register address, only the low nibble is meaningful
   typedef logic [3:0] max_addr_t;

   // MAX7219 register value
   typedef logic [7:0] max_data_t;

   // Bits shifted per MAX7219 frame
   localparam int FRAME_BITS = 16;

   // Frame layout: 4 don't-care zeros, address, data
   typedef logic [FRAME_BITS-1:0] max_frame_t;

   // ============================================================
   // State machines
   // ============================================================

   // UART receiver
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // MAX7219 serializer
   typedef enum logic [1:0] {
      SER_IDLE,
      SER_SHIFT,
      SER_LOAD
   } ser_state_t;

endpackage

`default_nettype wire
